/* source/alu_pkg.sv */
`default_nettype none

package alu_pkg;

	// container and operand width
	localparam int data_width = 32;

	// action word layout, opcode sits in the top nibble
	localparam int action_width = 25;
	localparam int opcode_msb = 24;
	localparam int opcode_lsb = 21;

	typedef logic [data_width-1:0] data_t;
	typedef logic [action_width-1:0] action_t;

	// op_pass is never on the wire, the decoder picks it for unknown codes
	typedef enum logic [3:0] {
		op_pass  = 4'b0000,
		op_add   = 4'b0001,
		op_sub   = 4'b0010,
		op_loadd = 4'b0111,
		op_store = 4'b1000,
		op_addi  = 4'b1001,
		op_subi  = 4'b1010,
		op_load  = 4'b1011
	} alu_op_e;

	// one item in flight, one cycle per state
	typedef enum logic [1:0] {
		exec_idle,
		exec_lookup,
		exec_access,
		exec_done
	} exec_state_e;

endpackage

`default_nettype wire

/* source/tenant_mem_pkg.sv */
`default_nettype none

package tenant_mem_pkg;

	// page table geometry
	localparam int tenant_count = 16;
	typedef logic [$clog2(tenant_count)-1:0] tenant_t;

	// tenant index is vlan bits 7:4
	localparam int vlan_tenant_lsb = 4;

	typedef logic [7:0] page_base_t;
	typedef logic [7:0] page_len_t;

	// data memory geometry
	localparam int ram_depth = 32;
	typedef logic [$clog2(ram_depth)-1:0] ram_addr_t;

	// offset comes from operand 2 bits 4:0
	typedef logic [4:0] offset_t;

endpackage

`default_nettype wire

/* source/action_decode.sv */
`timescale 1ns/1ps
`default_nettype none

module action_decode (
	input  logic                    clk,
	input  logic                    rst_n,
	input  alu_pkg::action_t        action,
	input  alu_pkg::data_t          operand_1,
	input  alu_pkg::data_t          operand_2,
	input  alu_pkg::data_t          operand_3,
	input  logic [11:0]             vlan_id,
	input  logic                    action_valid,
	output logic                    action_ready,
	output logic                    dec_valid,
	input  logic                    dec_ready,
	output alu_pkg::alu_op_e        dec_op,
	output alu_pkg::data_t          dec_op_1,
	output alu_pkg::data_t          dec_op_2,
	output alu_pkg::data_t          dec_op_3,
	output tenant_mem_pkg::tenant_t dec_tenant,
	output tenant_mem_pkg::offset_t dec_offset
);
	import alu_pkg::*;

	logic    accept;
	alu_op_e op_map;

	// buffer free, or draining on this edge
	assign action_ready = !dec_valid || dec_ready;
	assign accept = action_valid && action_ready;

	always_comb begin
		case (action[opcode_msb:opcode_lsb])
			op_add, op_sub, op_addi, op_subi,
			op_store, op_load, op_loadd: begin
				op_map = alu_op_e'(action[opcode_msb:opcode_lsb]);
			end
			default: begin
				op_map = op_pass;
			end
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			dec_valid <= 1'b0;
		end else if (accept) begin
			dec_valid <= 1'b1;
		end else if (dec_ready) begin
			dec_valid <= 1'b0;
		end
	end

	// payload, loaded only on a handshake
	always_ff @(posedge clk) begin
		if (accept) begin
			dec_op <= op_map;
			dec_op_1 <= operand_1;
			dec_op_2 <= operand_2;
			dec_op_3 <= operand_3;
			dec_tenant <= vlan_id[tenant_mem_pkg::vlan_tenant_lsb +: $bits(dec_tenant)];
			dec_offset <= operand_2[$bits(dec_offset)-1:0];
		end
	end

	// a stalled item must not change under the execute stage
	assert property (@(posedge clk) disable iff (!rst_n)
		dec_valid && !dec_ready |=> dec_valid && $stable(dec_op) && $stable(dec_op_1)
			&& $stable(dec_op_2) && $stable(dec_op_3) && $stable(dec_tenant)
			&& $stable(dec_offset));

endmodule

`default_nettype wire

/* source/stateful_execute.sv */
`timescale 1ns/1ps
`default_nettype none

module stateful_execute (
	input  logic                       clk,
	input  logic                       rst_n,
	input  logic                       dec_valid,
	output logic                       dec_ready,
	input  alu_pkg::alu_op_e           dec_op,
	input  alu_pkg::data_t             dec_op_1,
	input  alu_pkg::data_t             dec_op_2,
	input  alu_pkg::data_t             dec_op_3,
	input  tenant_mem_pkg::tenant_t    dec_tenant,
	input  tenant_mem_pkg::offset_t    dec_offset,
	output tenant_mem_pkg::tenant_t    pt_tenant,
	input  tenant_mem_pkg::page_base_t pt_base,
	input  tenant_mem_pkg::page_len_t  pt_len,
	output tenant_mem_pkg::ram_addr_t  ram_rd_addr,
	input  alu_pkg::data_t             ram_rd_data,
	output logic                       ram_wr_en,
	output tenant_mem_pkg::ram_addr_t  ram_wr_addr,
	output alu_pkg::data_t             ram_wr_data,
	output logic                       exe_valid,
	input  logic                       exe_ready,
	output alu_pkg::data_t             exe_value,
	output logic                       exe_overflow
);
	import alu_pkg::*;
	import tenant_mem_pkg::*;

	exec_state_e state;
	alu_op_e     op_q;
	data_t       op1_q;
	data_t       op2_q;
	data_t       op3_q;
	offset_t     offset_q;
	ram_addr_t   addr_q;
	ram_addr_t   mem_addr;
	page_base_t  phys_sum;
	logic        is_mem_op;
	logic        ovf_now;
	logic        ovf_q;

	assign dec_ready = (state == exec_idle);
	assign exe_valid = (state == exec_done);

	// page table read issued on the accepting edge
	assign pt_tenant = dec_tenant;

	assign is_mem_op = (op_q == op_store) || (op_q == op_load) || (op_q == op_loadd);

	// bounds check is only valid while in exec_lookup
	assign ovf_now = is_mem_op && (page_len_t'(offset_q) > pt_len);
	assign phys_sum = pt_base + page_base_t'(offset_q);

	// address held after lookup so the read data stays put through exec_done
	assign mem_addr = (state == exec_lookup) ? phys_sum[$bits(ram_addr_t)-1:0] : addr_q;
	assign ram_rd_addr = mem_addr;
	assign ram_wr_addr = mem_addr;

	// store at end of lookup and loadd write-back when the result leaves
	assign ram_wr_en = ((state == exec_lookup) && (op_q == op_store) && !ovf_now)
		|| ((state == exec_done) && (op_q == op_loadd) && !ovf_q && exe_ready);
	assign ram_wr_data = (op_q == op_store) ? op1_q : ram_rd_data + data_t'(1);

	always_comb begin
		case (op_q)
			op_add, op_addi: begin
				exe_value = op1_q + op2_q;
			end
			op_sub, op_subi: begin
				exe_value = op1_q - op2_q;
			end
			op_load: begin
				exe_value = ovf_q ? op3_q : ram_rd_data;
			end
			op_loadd: begin
				exe_value = ovf_q ? op3_q : ram_rd_data + data_t'(1);
			end
			// store and pass hand operand 3 back
			default: begin
				exe_value = op3_q;
			end
		endcase
	end

	assign exe_overflow = ovf_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= exec_idle;
		end else begin
			case (state)
				exec_idle: begin
					if (dec_valid) begin
						state <= exec_lookup;
					end
				end
				exec_lookup: begin
					state <= exec_access;
				end
				exec_access: begin
					state <= exec_done;
				end
				exec_done: begin
					if (exe_ready) begin
						state <= exec_idle;
					end
				end
				default: begin
					state <= exec_idle;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (dec_ready && dec_valid) begin
			op_q <= dec_op;
			op1_q <= dec_op_1;
			op2_q <= dec_op_2;
			op3_q <= dec_op_3;
			offset_q <= dec_offset;
		end
		// page entry is only present during lookup
		if (state == exec_lookup) begin
			addr_q <= phys_sum[$bits(ram_addr_t)-1:0];
			ovf_q <= ovf_now;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n)
		exe_valid && exe_overflow |-> !ram_wr_en);

	// result held until taken
	assert property (@(posedge clk) disable iff (!rst_n)
		exe_valid && !exe_ready |=> exe_valid && $stable(exe_value) && $stable(exe_overflow));

endmodule

`default_nettype wire

/* source/result_stage.sv */
`timescale 1ns/1ps
`default_nettype none

module result_stage (
	input  logic           clk,
	input  logic           rst_n,
	input  logic           exe_valid,
	output logic           exe_ready,
	input  alu_pkg::data_t exe_value,
	input  logic           exe_overflow,
	output logic           result_valid,
	input  logic           result_ready,
	output alu_pkg::data_t container,
	output logic           overflow
);
	import alu_pkg::*;

	data_t      value_q [2];
	logic [1:0] ovf_q;
	logic       wr_ptr;
	logic       rd_ptr;
	logic [1:0] count;
	logic       push;
	logic       pop;

	assign exe_ready = (count < 2'd2);
	assign result_valid = (count != 2'd0);
	assign push = exe_valid && exe_ready;
	assign pop = result_valid && result_ready;

	// oldest entry on the output
	assign container = value_q[rd_ptr];
	assign overflow = ovf_q[rd_ptr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr <= 1'b0;
			rd_ptr <= 1'b0;
			count <= 2'd0;
		end else begin
			if (push) begin
				wr_ptr <= !wr_ptr;
			end
			if (pop) begin
				rd_ptr <= !rd_ptr;
			end
			// push and pop together leave the count alone
			count <= count + {1'b0, push} - {1'b0, pop};
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			value_q[wr_ptr] <= exe_value;
			ovf_q[wr_ptr] <= exe_overflow;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) count <= 2'd2);

endmodule

`default_nettype wire

/* source/page_table.sv */
`timescale 1ns/1ps
`default_nettype none

module page_table (
	input  logic                       clk,
	input  logic                       cfg_valid,
	input  tenant_mem_pkg::tenant_t    cfg_tenant,
	input  tenant_mem_pkg::page_base_t cfg_base,
	input  tenant_mem_pkg::page_len_t  cfg_len,
	input  tenant_mem_pkg::tenant_t    pt_tenant,
	output tenant_mem_pkg::page_base_t pt_base,
	output tenant_mem_pkg::page_len_t  pt_len
);
	import tenant_mem_pkg::*;

	page_base_t base_mem [tenant_count];
	page_len_t  len_mem [tenant_count];

	// config write lands in one cycle
	always_ff @(posedge clk) begin
		if (cfg_valid) begin
			base_mem[cfg_tenant] <= cfg_base;
			len_mem[cfg_tenant] <= cfg_len;
		end
	end

	// registered lookup, old entry on a same-cycle write
	always_ff @(posedge clk) begin
		pt_base <= base_mem[pt_tenant];
		pt_len <= len_mem[pt_tenant];
	end

endmodule

`default_nettype wire

/* source/data_ram.sv */
`timescale 1ns/1ps
`default_nettype none

module data_ram (
	input  logic                      clk,
	input  logic                      ram_wr_en,
	input  tenant_mem_pkg::ram_addr_t ram_wr_addr,
	input  alu_pkg::data_t            ram_wr_data,
	input  tenant_mem_pkg::ram_addr_t ram_rd_addr,
	output alu_pkg::data_t            ram_rd_data
);
	import tenant_mem_pkg::*;

	// shared key-value words for all tenants
	alu_pkg::data_t mem [ram_depth];

	always_ff @(posedge clk) begin
		if (ram_wr_en) begin
			mem[ram_wr_addr] <= ram_wr_data;
		end
	end

	// one cycle read latency
	always_ff @(posedge clk) begin
		ram_rd_data <= mem[ram_rd_addr];
	end

endmodule

`default_nettype wire

/* source/stateful_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module stateful_alu (
	input  logic                       clk,
	input  logic                       rst_n,
	input  alu_pkg::action_t           action,
	input  alu_pkg::data_t             operand_1,
	input  alu_pkg::data_t             operand_2,
	input  alu_pkg::data_t             operand_3,
	input  logic [11:0]                vlan_id,
	input  logic                       action_valid,
	output logic                       action_ready,
	output logic                       result_valid,
	input  logic                       result_ready,
	output alu_pkg::data_t             container,
	output logic                       overflow,
	input  logic                       cfg_valid,
	input  tenant_mem_pkg::tenant_t    cfg_tenant,
	input  tenant_mem_pkg::page_base_t cfg_base,
	input  tenant_mem_pkg::page_len_t  cfg_len
);
	import alu_pkg::*;
	import tenant_mem_pkg::*;

	// decode to execute
	logic       dec_valid;
	logic       dec_ready;
	alu_op_e    dec_op;
	data_t      dec_op_1;
	data_t      dec_op_2;
	data_t      dec_op_3;
	tenant_t    dec_tenant;
	offset_t    dec_offset;

	// execute to memories
	tenant_t    pt_tenant;
	page_base_t pt_base;
	page_len_t  pt_len;
	logic       ram_wr_en;
	ram_addr_t  ram_wr_addr;
	data_t      ram_wr_data;
	ram_addr_t  ram_rd_addr;
	data_t      ram_rd_data;

	// execute to result queue
	logic       exe_valid;
	logic       exe_ready;
	data_t      exe_value;
	logic       exe_overflow;

	action_decode i_action_decode (
		.clk          (clk),
		.rst_n        (rst_n),
		.action       (action),
		.operand_1    (operand_1),
		.operand_2    (operand_2),
		.operand_3    (operand_3),
		.vlan_id      (vlan_id),
		.action_valid (action_valid),
		.action_ready (action_ready),
		.dec_valid    (dec_valid),
		.dec_ready    (dec_ready),
		.dec_op       (dec_op),
		.dec_op_1     (dec_op_1),
		.dec_op_2     (dec_op_2),
		.dec_op_3     (dec_op_3),
		.dec_tenant   (dec_tenant),
		.dec_offset   (dec_offset)
	);

	stateful_execute i_stateful_execute (
		.clk          (clk),
		.rst_n        (rst_n),
		.dec_valid    (dec_valid),
		.dec_ready    (dec_ready),
		.dec_op       (dec_op),
		.dec_op_1     (dec_op_1),
		.dec_op_2     (dec_op_2),
		.dec_op_3     (dec_op_3),
		.dec_tenant   (dec_tenant),
		.dec_offset   (dec_offset),
		.pt_tenant    (pt_tenant),
		.pt_base      (pt_base),
		.pt_len       (pt_len),
		.ram_rd_addr  (ram_rd_addr),
		.ram_rd_data  (ram_rd_data),
		.ram_wr_en    (ram_wr_en),
		.ram_wr_addr  (ram_wr_addr),
		.ram_wr_data  (ram_wr_data),
		.exe_valid    (exe_valid),
		.exe_ready    (exe_ready),
		.exe_value    (exe_value),
		.exe_overflow (exe_overflow)
	);

	result_stage i_result_stage (
		.clk          (clk),
		.rst_n        (rst_n),
		.exe_valid    (exe_valid),
		.exe_ready    (exe_ready),
		.exe_value    (exe_value),
		.exe_overflow (exe_overflow),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.container    (container),
		.overflow     (overflow)
	);

	page_table i_page_table (
		.clk        (clk),
		.cfg_valid  (cfg_valid),
		.cfg_tenant (cfg_tenant),
		.cfg_base   (cfg_base),
		.cfg_len    (cfg_len),
		.pt_tenant  (pt_tenant),
		.pt_base    (pt_base),
		.pt_len     (pt_len)
	);

	data_ram i_data_ram (
		.clk         (clk),
		.ram_wr_en   (ram_wr_en),
		.ram_wr_addr (ram_wr_addr),
		.ram_wr_data (ram_wr_data),
		.ram_rd_addr (ram_rd_addr),
		.ram_rd_data (ram_rd_data)
	);

endmodule

`default_nettype wire

/* dv/tb_stateful_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_stateful_alu;
	import alu_pkg::*;
	import tenant_mem_pkg::*;

	localparam int wait_limit = 50;

	logic        clk;
	logic        rst_n;
	action_t     action;
	data_t       operand_1;
	data_t       operand_2;
	data_t       operand_3;
	logic [11:0] vlan_id;
	logic        action_valid;
	logic        action_ready;
	logic        result_valid;
	logic        result_ready;
	data_t       container;
	logic        overflow;
	logic        cfg_valid;
	tenant_t     cfg_tenant;
	page_base_t  cfg_base;
	page_len_t   cfg_len;

	stateful_alu i_stateful_alu (
		.clk          (clk),
		.rst_n        (rst_n),
		.action       (action),
		.operand_1    (operand_1),
		.operand_2    (operand_2),
		.operand_3    (operand_3),
		.vlan_id      (vlan_id),
		.action_valid (action_valid),
		.action_ready (action_ready),
		.result_valid (result_valid),
		.result_ready (result_ready),
		.container    (container),
		.overflow     (overflow),
		.cfg_valid    (cfg_valid),
		.cfg_tenant   (cfg_tenant),
		.cfg_base     (cfg_base),
		.cfg_len      (cfg_len)
	);

	always #5 clk = ~clk;

	task automatic abort_run(input string what);
		$display("%s", what);
		$display(">>> FAIL");
		$fatal(1, "simulation stopped");
	endtask

	task automatic value_error(input string msg);
		abort_run($sformatf("ERROR at %0t ns: %s", $time, msg));
	endtask

	task automatic check_container(input string what, input data_t got, input data_t exp);
		if (got !== exp) begin
			value_error($sformatf("%s: container 0x%08h, expected 0x%08h", what, got, exp));
		end
	endtask

	task automatic check_overflow(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_error($sformatf("%s: overflow %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_level(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			value_error($sformatf("%s is %b, expected %b", what, got, exp));
		end
	endtask

	task automatic check_count(input string what, input int got, input int exp);
		if (got != exp) begin
			value_error($sformatf("%s is %0d, expected %0d", what, got, exp));
		end
	endtask

	// sum or difference modulo 2^32 by opcode
	function automatic data_t arith_expected(input alu_op_e code, input data_t a, input data_t b);
		if (code == op_add || code == op_addi) begin
			return a + b;
		end
		return a - b;
	endfunction

	// only the low five bits select the word
	function automatic data_t offset_operand(input offset_t offset);
		data_t value;
		value = $urandom;
		value[$bits(offset_t)-1:0] = offset;
		return value;
	endfunction

	task automatic configure_tenant(input tenant_t tenant, input page_base_t base,
		input page_len_t len);
		cfg_tenant = tenant;
		cfg_base = base;
		cfg_len = len;
		cfg_valid = 1'b1;
		@(posedge clk);
		#1;
		cfg_valid = 1'b0;
	endtask

	// unused action bits and vlan bits carry noise
	task automatic offer_action(input logic [3:0] code, input tenant_t tenant, input data_t op1,
		input data_t op2, input data_t op3, input int max_cycles, output bit accepted);
		action_t     word;
		logic [11:0] vlan;
		int          cycles;
		word = action_t'($urandom);
		word[opcode_msb:opcode_lsb] = code;
		vlan = 12'($urandom);
		vlan[vlan_tenant_lsb +: $bits(tenant_t)] = tenant;
		action = word;
		vlan_id = vlan;
		operand_1 = op1;
		operand_2 = op2;
		operand_3 = op3;
		action_valid = 1'b1;
		accepted = 1'b0;
		cycles = 0;
		while (!accepted && cycles < max_cycles) begin
			@(negedge clk);
			accepted = action_ready;
			@(posedge clk);
			#1;
			cycles++;
		end
		action_valid = 1'b0;
	endtask

	task automatic send_action(input logic [3:0] code, input tenant_t tenant, input data_t op1,
		input data_t op2, input data_t op3);
		bit accepted;
		offer_action(code, tenant, op1, op2, op3, wait_limit, accepted);
		if (!accepted) begin
			abort_run($sformatf("timeout: action not accepted within %0d cycles", wait_limit));
		end
	endtask

	// edges counts rising edges seen before result_valid was high
	task automatic get_result(output data_t value, output logic ovf, output int edges);
		bit seen;
		seen = 1'b0;
		edges = 0;
		result_ready = 1'b1;
		while (!seen) begin
			@(negedge clk);
			if (result_valid) begin
				seen = 1'b1;
				value = container;
				ovf = overflow;
			end
			@(posedge clk);
			#1;
			if (!seen) begin
				edges++;
				if (edges > wait_limit) begin
					abort_run($sformatf("timeout: no result within %0d cycles", wait_limit));
				end
			end
		end
		result_ready = 1'b0;
	endtask

	task automatic expect_action(input string what, input logic [3:0] code, input tenant_t tenant,
		input data_t op1, input data_t op2, input data_t op3, input data_t exp_value,
		input logic exp_ovf);
		data_t got;
		logic  ovf;
		int    edges;
		send_action(code, tenant, op1, op2, op3);
		get_result(got, ovf, edges);
		check_container(what, got, exp_value);
		check_overflow(what, ovf, exp_ovf);
	endtask

	task automatic test_reset();
		@(negedge clk);
		check_level("action_ready after reset", action_ready, 1'b1);
		check_level("result_valid after reset", result_valid, 1'b0);
		@(posedge clk);
		#1;
	endtask

	task automatic test_arithmetic();
		alu_op_e    ops[$] = '{op_add, op_sub, op_addi, op_subi};
		logic [3:0] unknown[$] = '{4'b0000, 4'b0011, 4'b0110, 4'b1111};
		data_t      a;
		data_t      b;
		data_t      c;
		data_t      got;
		logic       ovf;
		int         edges;
		// first pass also measures latency through an empty pipeline
		a = $urandom;
		b = $urandom;
		send_action(op_add, 4'd1, a, b, $urandom);
		get_result(got, ovf, edges);
		check_count("edges from accept to result_valid", edges, 4);
		check_container("first add", got, a + b);
		repeat (3) begin
			foreach (ops[k]) begin
				a = $urandom;
				b = $urandom;
				expect_action(ops[k].name(), ops[k], 4'd1, a, b, $urandom,
					arith_expected(ops[k], a, b), 1'b0);
			end
		end
		expect_action("add wraps", op_add, 4'd1, 32'hffff_ffff, 32'd2, $urandom, 32'd1, 1'b0);
		expect_action("sub wraps", op_subi, 4'd1, 32'd1, 32'd3, $urandom, 32'hffff_fffe, 1'b0);
		foreach (unknown[k]) begin
			c = $urandom;
			expect_action($sformatf("unknown code %b", unknown[k]), unknown[k], 4'd1,
				$urandom, $urandom, c, c, 1'b0);
		end
	endtask

	task automatic test_isolation();
		data_t val_a;
		data_t val_b;
		data_t c;
		val_a = $urandom;
		val_b = $urandom;
		configure_tenant(4'd1, 8'd0, 8'd10);
		configure_tenant(4'd2, 8'd16, 8'd10);
		c = $urandom;
		expect_action("store tenant 1", op_store, 4'd1, val_a, offset_operand(5'd3), c, c, 1'b0);
		c = $urandom;
		expect_action("store tenant 2", op_store, 4'd2, val_b, offset_operand(5'd3), c, c, 1'b0);
		expect_action("load tenant 1", op_load, 4'd1, $urandom, offset_operand(5'd3), $urandom,
			val_a, 1'b0);
		expect_action("load tenant 2", op_load, 4'd2, $urandom, offset_operand(5'd3), $urandom,
			val_b, 1'b0);
	endtask

	task automatic test_loadd();
		data_t v;
		data_t c;
		v = $urandom;
		c = $urandom;
		expect_action("store before loadd", op_store, 4'd1, v, offset_operand(5'd5), c, c, 1'b0);
		expect_action("first loadd", op_loadd, 4'd1, $urandom, offset_operand(5'd5), $urandom,
			v + 32'd1, 1'b0);
		expect_action("second loadd", op_loadd, 4'd1, $urandom, offset_operand(5'd5), $urandom,
			v + 32'd2, 1'b0);
		expect_action("load after loadd", op_load, 4'd1, $urandom, offset_operand(5'd5),
			$urandom, v + 32'd2, 1'b0);
	endtask

	task automatic test_overflow();
		data_t kept;
		data_t edge_val;
		data_t c;
		kept = $urandom;
		edge_val = $urandom;
		// tenant 2 offset 4 and tenant 1 offset 20 both map to word 20
		c = $urandom;
		expect_action("store tenant 2 word 20", op_store, 4'd2, kept, offset_operand(5'd4), c, c,
			1'b0);
		c = $urandom;
		expect_action("store past length", op_store, 4'd1, $urandom, offset_operand(5'd20), c, c,
			1'b1);
		c = $urandom;
		expect_action("load past length", op_load, 4'd1, $urandom, offset_operand(5'd20), c, c,
			1'b1);
		c = $urandom;
		expect_action("loadd past length", op_loadd, 4'd1, $urandom, offset_operand(5'd31), c, c,
			1'b1);
		expect_action("aliased word untouched", op_load, 4'd2, $urandom, offset_operand(5'd4),
			$urandom, kept, 1'b0);
		// offset equal to the length is still in bounds
		c = $urandom;
		expect_action("store at length", op_store, 4'd1, edge_val, offset_operand(5'd10), c, c,
			1'b0);
		expect_action("load at length", op_load, 4'd1, $urandom, offset_operand(5'd10), $urandom,
			edge_val, 1'b0);
		c = $urandom;
		expect_action("store one past length", op_store, 4'd1, $urandom, offset_operand(5'd11), c,
			c, 1'b1);
	endtask

	task automatic test_backpressure();
		data_t a_q[$];
		data_t b_q[$];
		data_t a;
		data_t b;
		data_t got;
		logic  ovf;
		bit    accepted;
		int    taken;
		int    edges;
		result_ready = 1'b0;
		taken = 0;
		accepted = 1'b1;
		while (accepted) begin
			a = $urandom;
			b = $urandom;
			offer_action(op_add, 4'd1, a, b, $urandom, 8, accepted);
			if (accepted) begin
				a_q.push_back(a);
				b_q.push_back(b);
				taken++;
			end
			if (taken > 10) begin
				abort_run("action_ready never fell while results were held back");
			end
		end
		// result queue, execute stage and decode buffer
		check_count("actions taken under back-pressure", taken, 4);
		foreach (a_q[k]) begin
			get_result(got, ovf, edges);
			check_container($sformatf("held add #%0d", k), got, a_q[k] + b_q[k]);
			check_overflow($sformatf("held add #%0d", k), ovf, 1'b0);
		end
		repeat (6) @(posedge clk);
		@(negedge clk);
		check_level("result_valid after drain", result_valid, 1'b0);
		check_level("action_ready after drain", action_ready, 1'b1);
		@(posedge clk);
		#1;
	endtask

	initial begin
		int seed_value;
		seed_value = $urandom(75);
		clk = 1'b0;
		rst_n = 1'b0;
		action = '0;
		operand_1 = '0;
		operand_2 = '0;
		operand_3 = '0;
		vlan_id = '0;
		action_valid = 1'b0;
		result_ready = 1'b0;
		cfg_valid = 1'b0;
		cfg_tenant = '0;
		cfg_base = '0;
		cfg_len = '0;
		repeat (4) @(posedge clk);
		#1;
		rst_n = 1'b1;
		test_reset();
		test_arithmetic();
		test_isolation();
		test_loadd();
		test_overflow();
		test_backpressure();
		$display(">>> PASS");
		$finish;
	end

endmodule

`default_nettype wire

/* filelist.f */
source/alu_pkg.sv
source/tenant_mem_pkg.sv
source/action_decode.sv
source/stateful_execute.sv
source/result_stage.sv
source/page_table.sv
source/data_ram.sv
source/stateful_alu.sv
dv/tb_stateful_alu.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_stateful_alu
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q ">>> PASS" $(LOG) || (echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
